/* all.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_access.sv
rv_core_top.sv
tb_asserts.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_top -f all.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tb_top.sv */
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          ntests    = 24;
  localparam int          halt_max  = 200;
  localparam logic [31:0] ebreak_w  = 32'h0010_0073;
  localparam logic [31:0] data_addr = 32'h8000_0080; // word 32
  localparam logic [31:0] out_addr  = 32'h8000_0084; // load results go here
  localparam logic [31:0] load_word = 32'h8c7f_f501;

  logic                    clk;
  logic                    rst_n;
  logic                    load_img;
  logic [rv_pkg::xlen-1:0] imem_addr;
  logic [rv_pkg::xlen-1:0] imem_data;
  logic [rv_pkg::xlen-1:0] dmem_rdata;
  logic [rv_pkg::xlen-1:0] byte_en;
  rv_pkg::dmem_req_t       dmem_req;
  logic                    halted;

  logic [31:0]       mem      [64]; // code from word 0, data from word 32
  logic [31:0]       image    [64];
  logic [31:0]       prog_buf [8];
  string             name_tbl [ntests];
  logic [31:0]       prog_tbl [ntests][8];
  logic [31:0]       pre_tbl  [ntests];
  rv_pkg::dmem_req_t exp_tbl  [ntests];
  int                rd_tbl   [ntests]; // expected data reads
  int                n_tests;
  int                n_words;
  int                n_loads;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  rv_core_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  tb_checker chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .dmem_req (dmem_req),
    .halted   (halted)
  );

  assign imem_data  = mem[imem_addr[7:2]];
  assign dmem_rdata = mem[dmem_req.addr[7:2]];
  assign byte_en    = {{8{dmem_req.wmask[3]}}, {8{dmem_req.wmask[2]}},
                       {8{dmem_req.wmask[1]}}, {8{dmem_req.wmask[0]}}};

  always_ff @(posedge clk) begin
    if (load_img) begin
      mem <= image;
    end else if (dmem_req.write) begin
      mem[dmem_req.addr[7:2]] <= (mem[dmem_req.addr[7:2]] & ~byte_en)
                               | (dmem_req.wdata & byte_en);
    end
  end

  function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [4:0] rd,
      input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype_word(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opc_store};
  endfunction

  function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
      input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal};
  endfunction

  // expected value of a load, straight from the lane and extension rule
  function automatic logic [31:0] load_value(input logic [31:0] word, input logic [2:0] f3,
      input int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(word >> (8 * off));
    h = 16'(word >> (8 * off));
    case (f3)
      rv_pkg::f3_byte:   return {{24{b[7]}}, b};
      rv_pkg::f3_byte_u: return {24'h0, b};
      rv_pkg::f3_half:   return {{16{h[15]}}, h};
      default:           return {16'h0, h};
    endcase
  endfunction

  task automatic push_inst(input logic [31:0] w);
    prog_buf[3'(n_words)] = w;
    if (w[6:0] == rv_pkg::opc_load) n_loads++; // one data read per load
    n_words++;
  endtask

  task automatic add_test(input string name, input logic [31:0] pre, input logic [31:0] addr,
      input logic [31:0] data, input logic [3:0] mask);
    int         i;
    logic [4:0] t;
    t = 5'(n_tests);
    for (i = 0; i < 8; i++) begin
      prog_tbl[t][3'(i)] = (i < n_words) ? prog_buf[3'(i)] : ebreak_w;
    end
    name_tbl[t] = name;
    pre_tbl[t]  = pre;
    exp_tbl[t]  = '{addr: addr, wdata: data, wmask: mask, read: 1'b0, write: 1'b1};
    rd_tbl[t]   = n_loads;
    n_tests++;
    n_words = 0;
    n_loads = 0;
  endtask

  task automatic set_base();
    push_inst(utype_word(rv_pkg::opc_lui, 5'd1, 20'h80000)); // x1 = reset_pc
  endtask

  task automatic set_pattern();
    push_inst(utype_word(rv_pkg::opc_lui, 5'd8, 20'ha5b6c));
    push_inst(itype_word(rv_pkg::opc_op_imm, 5'd8, 3'b000, 5'd8, 12'h07d)); // x8 = a5b6c07d
  endtask

  task automatic load_case(input string base, input logic [2:0] f3, input int off);
    set_base();
    push_inst(itype_word(rv_pkg::opc_load, 5'd7, f3, 5'd1, 12'(128 + off)));
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd7, 12'd132));
    push_inst(ebreak_w);
    add_test($sformatf("%s_off%0d", base, off), load_word, out_addr,
             load_value(load_word, f3, off), 4'b1111);
  endtask

  task automatic build_table();
    int off;
    n_tests = 0;
    n_words = 0;
    n_loads = 0;
    set_base();
    push_inst(utype_word(rv_pkg::opc_lui, 5'd2, 20'h12345));
    push_inst(itype_word(rv_pkg::opc_op_imm, 5'd2, 3'b000, 5'd2, 12'hff0)); // minus 16
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd2, 12'd128));
    push_inst(ebreak_w);
    add_test("addi_lui", 32'h0, data_addr, 32'h1234_4ff0, 4'b1111);
    set_base();
    push_inst(jtype_word(5'd3, 21'd8)); // jal at 80000004
    push_inst(itype_word(rv_pkg::opc_op_imm, 5'd3, 3'b000, 5'd0, 12'h7ff)); // skipped
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd3, 12'd128));
    push_inst(ebreak_w);
    add_test("jal_link", 32'h0, data_addr, 32'h8000_0008, 4'b1111);
    set_base();
    push_inst(utype_word(rv_pkg::opc_auipc, 5'd4, 20'h00012));
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd4, 12'd128));
    push_inst(ebreak_w);
    add_test("auipc", 32'h0, data_addr, 32'h8001_2004, 4'b1111);
    set_base();
    push_inst(utype_word(rv_pkg::opc_auipc, 5'd5, 20'h0));
    // odd target 80000011 lands on word 4
    push_inst(itype_word(rv_pkg::opc_jalr, 5'd6, 3'b000, 5'd5, 12'd13));
    push_inst(itype_word(rv_pkg::opc_op_imm, 5'd6, 3'b000, 5'd0, 12'd1));
    push_inst(utype_word(rv_pkg::opc_auipc, 5'd11, 20'h0)); // x11 = 80000010
    // pc based address goes misaligned if bit 0 of the target survived
    push_inst(stype_word(rv_pkg::f3_word, 5'd11, 5'd6, 12'd128));
    push_inst(ebreak_w);
    add_test("jalr_link", 32'h0, 32'h8000_0090, 32'h8000_000c, 4'b1111);
    for (off = 0; off < 4; off++) begin
      load_case("lb", rv_pkg::f3_byte, off);
      load_case("lbu", rv_pkg::f3_byte_u, off);
    end
    for (off = 0; off < 4; off += 2) begin
      load_case("lh", rv_pkg::f3_half, off);
      load_case("lhu", rv_pkg::f3_half_u, off);
    end
    for (off = 0; off < 4; off++) begin
      set_base();
      set_pattern();
      push_inst(stype_word(rv_pkg::f3_byte, 5'd1, 5'd8, 12'(128 + off)));
      push_inst(ebreak_w);
      add_test($sformatf("sb_off%0d", off), 32'h0, data_addr, 32'h7d << (8 * off),
               4'b0001 << off);
    end
    set_base();
    set_pattern();
    push_inst(stype_word(rv_pkg::f3_half, 5'd1, 5'd8, 12'd130));
    push_inst(ebreak_w);
    add_test("sh_off2", 32'h0, data_addr, 32'hc07d_0000, 4'b1100);
    set_base();
    push_inst(itype_word(rv_pkg::opc_load, 5'd9, rv_pkg::f3_word, 5'd1, 12'd129));
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd9, 12'd132));
    push_inst(ebreak_w);
    add_test("lw_misaligned", load_word, out_addr, 32'h0, 4'b1111);
    set_base();
    set_pattern();
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd8, 12'd128));
    push_inst(stype_word(rv_pkg::f3_half, 5'd1, 5'd8, 12'd133)); // odd half, no lanes
    push_inst(ebreak_w);
    add_test("sh_misaligned", 32'h0, data_addr, 32'ha5b6_c07d, 4'b1111);
    set_base();
    set_pattern();
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd8, 12'd128));
    push_inst(ebreak_w);
    push_inst(stype_word(rv_pkg::f3_word, 5'd1, 5'd0, 12'd132)); // never reached
    push_inst(stype_word(rv_pkg::f3_byte, 5'd1, 5'd0, 12'd128));
    add_test("halt_stops", 32'h0, data_addr, 32'ha5b6_c07d, 4'b1111);
  endtask

  task automatic run_test(input logic [4:0] t);
    int i;
    int cycles;
    for (i = 0; i < 64; i++) begin
      image[6'(i)] = rv_pkg::reset_pc + 32'(4 * i); // address as fill
    end
    for (i = 0; i < 8; i++) begin
      image[6'(i)] = prog_tbl[t][3'(i)];
    end
    image[32] = pre_tbl[t];
    @(posedge clk);
    rst_n    <= 1'b0;
    load_img <= 1'b1;
    @(posedge clk);
    load_img <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    while (!halted && cycles < halt_max) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      chk.note_timeout(name_tbl[t]);
    end else begin
      repeat (4) @(posedge clk); // a write after ebreak would land here
      chk.check_store(name_tbl[t], exp_tbl[t], rd_tbl[t]);
    end
  endtask

  initial begin
    rst_n    <= 1'b0;
    load_img <= 1'b0;
    build_table();
    for (int t = 0; t < n_tests; t++) begin
      run_test(5'(t));
    end
    @(posedge clk);
    $display("tests run %0d, passed %0d, failed %0d", n_tests, chk.n_pass, chk.n_fail);
    if (chk.n_fail == 0 && chk.n_pass == n_tests) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker (
  input logic              clk,
  input logic              rst_n,
  input rv_pkg::dmem_req_t dmem_req,
  input logic              halted
);
  timeunit 1ns;
  timeprecision 1ps;

  rv_pkg::dmem_req_t last_wr;
  logic              seen_wr;
  logic              wr_after_halt;
  int                rd_count; // data reads since reset
  int                n_pass = 0;
  int                n_fail = 0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_wr       <= '0;
      seen_wr       <= 1'b0;
      wr_after_halt <= 1'b0;
      rd_count      <= 0;
    end else begin
      if (dmem_req.read) rd_count <= rd_count + 1;
      // only writes that enable a lane change memory
      if (dmem_req.write && (dmem_req.wmask != '0)) begin
        last_wr <= dmem_req;
        seen_wr <= 1'b1;
        if (halted) wr_after_halt <= 1'b1;
      end
    end
  end

  task automatic check_store(input string name, input rv_pkg::dmem_req_t want,
      input int want_reads);
    if (!seen_wr) begin
      $display("test %s: no data write was observed", name);
      n_fail++;
    end else if (wr_after_halt) begin
      $display("test %s: a data write happened after the halt", name);
      n_fail++;
    end else if (last_wr.addr != want.addr || last_wr.wdata != want.wdata
                 || last_wr.wmask != want.wmask) begin
      $display(
        "Mismatch test %s: expected addr %h data %h mask %b, actual addr %h data %h mask %b",
        name, want.addr, want.wdata, want.wmask,
        last_wr.addr, last_wr.wdata, last_wr.wmask);
      n_fail++;
    end else if (rd_count != want_reads) begin
      $display("Mismatch test %s: expected %0d data reads, actual %0d",
               name, want_reads, rd_count);
      n_fail++;
    end else begin
      $display("test %s: ok", name);
      n_pass++;
    end
  endtask

  task automatic note_timeout(input string name);
    $display("test %s: core did not halt", name);
    n_fail++;
  endtask

endmodule

`default_nettype wire

/* tb_asserts.sv */
`default_nettype none

module tb_asserts (
  input logic                    clk,
  input logic                    rst_n,
  input rv_pkg::dmem_req_t       dmem_req,
  input logic [rv_pkg::xlen-1:0] pc,
  input logic                    halted
);
  timeunit 1ns;
  timeprecision 1ps;

  mask_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_req.wmask != '0) |-> dmem_req.write)
    else $error("wmask set without a write");

  no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_req.read && dmem_req.write))
    else $error("read and write set together");

  // pc frozen on the ebreak
  pc_held_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc))
    else $error("pc moved while halted");

  not_halted_after_reset: assert property (@(posedge clk) !rst_n |=> !halted)
    else $error("halted high right after reset");

endmodule

bind rv_core_top tb_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .dmem_req (dmem_req),
  .pc       (pc),
  .halted   (halted)
);

`default_nettype wire

/* rv_core_top.sv */
`default_nettype none

module rv_core_top (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0] imem_data,
  output rv_pkg::dmem_req_t       dmem_req,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic                    halted
);

  logic [rv_pkg::xlen-1:0] pc;
  logic                    running;
  rv_pkg::ctrl_t           ctrl;
  rv_pkg::exec_t           exec;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] wb_data;
  logic                    wb_en;

  assign imem_addr = pc;

  rv_fetch u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .next_pc (exec.next_pc),
    .halt    (ctrl.halt),
    .pc      (pc),
    .running (running),
    .halted  (halted)
  );

  rv_decode u_decode (
    .inst    (imem_data),
    .running (running), // control bits off outside run state
    .ctrl    (ctrl)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .we     (wb_en),
    .waddr  (ctrl.rd),
    .wdata  (wb_data),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_execute u_execute (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .exec     (exec)
  );

  rv_mem_access u_mem_access (
    .ctrl       (ctrl),
    .exec       (exec),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .wb_data    (wb_data),
    .wb_en      (wb_en)
  );

endmodule

`default_nettype wire

/* rv_mem_access.sv */
`default_nettype none

module rv_mem_access (
  input  rv_pkg::ctrl_t           ctrl,
  input  rv_pkg::exec_t           exec,
  input  logic [rv_pkg::xlen-1:0] pc,
  output rv_pkg::dmem_req_t       dmem_req,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic [rv_pkg::xlen-1:0] wb_data,
  output logic                    wb_en
);

  localparam int xlen = rv_pkg::xlen;

  logic [1:0]               offs;
  logic [4:0]               lane_shift; // byte offset in bits
  logic [rv_pkg::nbytes-1:0] st_mask;
  logic [xlen-1:0]          st_data;
  logic [xlen-1:0]          ld_shifted;
  logic [xlen-1:0]          ld_data;

  assign offs       = exec.sum[1:0];
  assign lane_shift = {offs, 3'b000};

  // store lane placement, misaligned leaves the mask at zero
  always_comb begin
    st_mask = '0;
    st_data = '0;
    case (ctrl.funct3)
      rv_pkg::f3_byte: begin
        st_mask = rv_pkg::nbytes'(1) << offs;
        st_data = xlen'(exec.store_data[7:0]) << lane_shift;
      end
      rv_pkg::f3_half: begin
        if (!offs[0]) begin
          st_mask = offs[1] ? 4'b1100 : 4'b0011;
          st_data = xlen'(exec.store_data[15:0]) << lane_shift;
        end
      end
      rv_pkg::f3_word: begin
        if (offs == 2'b00) begin
          st_mask = '1;
          st_data = exec.store_data;
        end
      end
      default: st_mask = '0;
    endcase
  end

  // selected lane moved down to bit 0
  assign ld_shifted = dmem_rdata >> lane_shift;

  always_comb begin
    ld_data = '0; // misaligned or bad size reads as zero
    case (ctrl.funct3)
      rv_pkg::f3_byte:   ld_data = {{(xlen-8){ld_shifted[7]}}, ld_shifted[7:0]};
      rv_pkg::f3_byte_u: ld_data = {{(xlen-8){1'b0}}, ld_shifted[7:0]};
      rv_pkg::f3_half: begin
        if (!offs[0]) ld_data = {{(xlen-16){ld_shifted[15]}}, ld_shifted[15:0]};
      end
      rv_pkg::f3_half_u: begin
        if (!offs[0]) ld_data = {{(xlen-16){1'b0}}, ld_shifted[15:0]};
      end
      rv_pkg::f3_word: begin
        if (offs == 2'b00) ld_data = dmem_rdata;
      end
      default: ld_data = '0;
    endcase
  end

  always_comb begin
    dmem_req       = '0;
    dmem_req.addr  = {exec.sum[xlen-1:2], 2'b00};
    dmem_req.wdata = st_data;
    dmem_req.wmask = ctrl.mem_write ? st_mask : '0;
    dmem_req.read  = ctrl.mem_read;
    dmem_req.write = ctrl.mem_write;
  end

  always_comb begin
    case (ctrl.wb_src)
      rv_pkg::wb_next_pc: wb_data = pc + xlen'(4); // link value
      rv_pkg::wb_load:    wb_data = ld_data;
      default:            wb_data = exec.sum;
    endcase
  end

  assign wb_en = ctrl.reg_write;

endmodule

`default_nettype wire

/* rv_execute.sv */
`default_nettype none

module rv_execute (
  input  rv_pkg::ctrl_t           ctrl,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::exec_t           exec
);

  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] sum;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] target;

  // first operand of the one shared adder
  always_comb begin
    if (ctrl.use_zero) begin
      op_a = '0; // lui
    end else if (ctrl.use_pc) begin
      op_a = pc; // auipc, jal
    end else begin
      op_a = rs1_data;
    end
  end

  assign sum      = op_a + ctrl.imm;
  assign pc_plus4 = pc + rv_pkg::xlen'(4);

  // jalr drops bit 0 of the computed target
  assign target = ctrl.use_pc ? sum : {sum[rv_pkg::xlen-1:1], 1'b0};

  always_comb begin
    exec            = '0;
    exec.sum        = sum;
    exec.next_pc    = ctrl.jump ? target : pc_plus4;
    exec.store_data = rs2_data;
  end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none

module rv_regfile (
  input  logic                          clk,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
  output logic [rv_pkg::xlen-1:0]       rdata1,
  output logic [rv_pkg::xlen-1:0]       rdata2
);

  localparam int nregs = 2 ** rv_pkg::reg_addr_w;

  logic [rv_pkg::xlen-1:0] regs [1:nregs-1]; // no storage for x0

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* rv_decode.sv */
`default_nettype none

module rv_decode (
  input  logic [rv_pkg::xlen-1:0] inst,
  input  logic                    running,
  output rv_pkg::ctrl_t           ctrl
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic                    is_ebreak;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // sign extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // imm=1 with rs1, funct3 and rd all zero
  assign is_ebreak = (inst[31:20] == 12'h001) && (inst[19:7] == '0);

  always_comb begin
    ctrl        = '0;
    ctrl.rd     = inst[11:7];
    ctrl.rs1    = inst[19:15];
    ctrl.rs2    = inst[24:20];
    ctrl.funct3 = funct3;
    ctrl.wb_src = rv_pkg::wb_sum;

    if (running) begin
      case (opcode)
        rv_pkg::opc_op_imm: begin
          if (funct3 == 3'b000) begin // addi only
            ctrl.imm       = imm_i;
            ctrl.reg_write = 1'b1;
          end
        end
        rv_pkg::opc_lui: begin
          ctrl.imm       = imm_u;
          ctrl.use_zero  = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        rv_pkg::opc_auipc: begin
          ctrl.imm       = imm_u;
          ctrl.use_pc    = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        rv_pkg::opc_jal: begin
          ctrl.imm       = imm_j;
          ctrl.use_pc    = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.jump      = 1'b1;
          ctrl.wb_src    = rv_pkg::wb_next_pc;
        end
        rv_pkg::opc_jalr: begin
          ctrl.imm       = imm_i;
          ctrl.reg_write = 1'b1;
          ctrl.jump      = 1'b1;
          ctrl.wb_src    = rv_pkg::wb_next_pc;
        end
        rv_pkg::opc_load: begin
          ctrl.imm       = imm_i;
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.wb_src    = rv_pkg::wb_load;
        end
        rv_pkg::opc_store: begin
          ctrl.imm       = imm_s;
          ctrl.mem_write = 1'b1;
        end
        rv_pkg::opc_system: ctrl.halt = is_ebreak;
        default: ctrl.imm = '0; // unsupported, plain pc+4
      endcase
    end
  end

endmodule

`default_nettype wire

/* rv_fetch.sv */
`default_nettype none

module rv_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [rv_pkg::xlen-1:0] next_pc,
  input  logic                    halt,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic                    running,
  output logic                    halted
);

  typedef enum logic [1:0] {
    st_reset,
    st_run,
    st_halt
  } state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_reset;
      pc    <= rv_pkg::reset_pc;
    end else begin
      case (state)
        st_reset: state <= st_run; // first fetch on the next cycle
        st_run: begin
          if (halt) begin
            state <= st_halt; // pc stays on the ebreak
          end else begin
            pc <= next_pc;
          end
        end
        default: state <= state; // halted until the next reset
      endcase
    end
  end

  assign running = (state == st_run);
  assign halted  = (state == st_halt);

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int nbytes     = 4;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_op_imm = 7'b001_0011;
  localparam logic [6:0] opc_lui    = 7'b011_0111;
  localparam logic [6:0] opc_auipc  = 7'b001_0111;
  localparam logic [6:0] opc_jal    = 7'b110_1111;
  localparam logic [6:0] opc_jalr   = 7'b110_0111;
  localparam logic [6:0] opc_load   = 7'b000_0011;
  localparam logic [6:0] opc_store  = 7'b010_0011;
  localparam logic [6:0] opc_system = 7'b111_0011;

  // funct3 access size for loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef enum logic [1:0] {
    wb_sum,     // adder output
    wb_next_pc, // link value pc+4
    wb_load     // extended load data
  } wb_src_e;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    logic [2:0]            funct3;
    logic                  use_pc;   // adder a = pc
    logic                  use_zero; // adder a = 0
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  jump;
    logic                  halt;
    wb_src_e               wb_src;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] sum;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] store_data; // raw rs2
  } exec_t;

  typedef struct packed {
    logic [xlen-1:0]   addr;  // word aligned
    logic [xlen-1:0]   wdata;
    logic [nbytes-1:0] wmask;
    logic              read;
    logic              write;
  } dmem_req_t;

endpackage

`default_nettype wire
